// ==== verilog/video_pkg.sv ====
/* video geometry package
   default display timing values and the timing bundle shared by the display path */
package video_pkg;

    // screen coordinate, wide enough for any total
    typedef logic [15:0] cord_t;

    // 640x480 at 60 Hz defaults
    localparam int H_ACTIVE_DEF     = 640;
    localparam int H_TOTAL_DEF      = 800;
    localparam int H_SYNC_START_DEF = 656;
    localparam int H_SYNC_END_DEF   = 752;  // sync is [start, end)

    localparam int V_ACTIVE_DEF     = 480;
    localparam int V_TOTAL_DEF      = 525;
    localparam int V_SYNC_START_DEF = 490;
    localparam int V_SYNC_END_DEF   = 492;

    // framebuffer pixel replicated SCALE times in x and y
    localparam int SCALE_DEF        = 2;

    // one screen position plus its decoded strobes
    typedef struct packed {
        cord_t sx;     // horizontal position
        cord_t sy;     // vertical position
        logic  hsync;  // active high
        logic  vsync;  // active high
        logic  de;     // inside active area
    } timing_t;

endpackage

// ==== verilog/pixel_pkg.sv ====
/* pixel and host write types
   palette index, rgb444 colour and the host write request */
package pixel_pkg;

    localparam int CIDX_W = 6;  // 64 palette entries

    typedef logic [CIDX_W-1:0] colour_idx_t;

    // 12 bit colour, r in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // which RAM a host write lands in
    typedef enum logic {
        WR_PALETTE = 1'b0,
        WR_FB      = 1'b1
    } wr_target_t;

    // held stable by the host while req is high
    typedef struct packed {
        wr_target_t  target;
        logic [16:0] addr;  // palette index or fb pixel address
        logic [11:0] data;  // rgb_t for palette, low 6 bits for fb
    } wr_req_t;

endpackage

// ==== verilog/dual_port_ram.sv ====
/* simple dual-port RAM
   one write port, one registered read port, payload set by a type parameter */
`timescale 1ns/10ps

module dual_port_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 64,
    localparam int ADDR_W    = $clog2(DEPTH)
) (
    input  logic              clk_pix,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  payload_t          wdata,
    input  logic [ADDR_W-1:0] raddr,
    output payload_t          rdata
);

    payload_t mem [DEPTH];  // maps to block RAM

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk_pix) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== verilog/display_timing.sv ====
/* display timing generator
   free running screen position counters with sync and active-area decode */
`timescale 1ns/10ps

module display_timing
    import video_pkg::*;
#(
    parameter int H_ACTIVE     = H_ACTIVE_DEF,
    parameter int H_TOTAL      = H_TOTAL_DEF,
    parameter int H_SYNC_START = H_SYNC_START_DEF,
    parameter int H_SYNC_END   = H_SYNC_END_DEF,
    parameter int V_ACTIVE     = V_ACTIVE_DEF,
    parameter int V_TOTAL      = V_TOTAL_DEF,
    parameter int V_SYNC_START = V_SYNC_START_DEF,
    parameter int V_SYNC_END   = V_SYNC_END_DEF
) (
    input  logic    clk_pix,
    input  logic    reset,
    output timing_t timing
);

    cord_t sx;  // current column
    cord_t sy;  // current line

    // one pixel per clock, wrap at the totals
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == cord_t'(H_TOTAL - 1)) begin
            sx <= '0;  // end of line
            if (sy == cord_t'(V_TOTAL - 1)) begin
                sy <= '0;  // end of frame
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // strobes decoded straight from the counters
    always_comb begin
        timing.sx    = sx;
        timing.sy    = sy;
        timing.hsync = (sx >= cord_t'(H_SYNC_START)) && (sx < cord_t'(H_SYNC_END));
        timing.vsync = (sy >= cord_t'(V_SYNC_START)) && (sy < cord_t'(V_SYNC_END));
        timing.de    = (sx < cord_t'(H_ACTIVE)) && (sy < cord_t'(V_ACTIVE));
    end

endmodule

// ==== verilog/host_write_port.sv ====
/* host write port
   four-phase req/ack slave, one write to palette or framebuffer per handshake */
`timescale 1ns/10ps

module host_write_port
    import pixel_pkg::*;
(
    input  logic        clk_pix,
    input  logic        reset,
    input  logic        req,
    input  wr_req_t     wr_req,
    output logic        ack,
    output logic        pal_we,
    output logic        fb_we,
    output logic [16:0] waddr,
    output logic [11:0] wdata
);

    typedef enum logic [1:0] {
        IDLE,      // waiting for req
        WRITE,     // write enable out this cycle
        ACK_HIGH,  // ack just raised
        WAIT_LOW   // ack held until req drops
    } state_t;

    state_t state;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state  <= IDLE;
            pal_we <= 1'b0;
            fb_we  <= 1'b0;
        end else begin
            pal_we <= 1'b0;  // enables are single cycle
            fb_we  <= 1'b0;
            case (state)
                IDLE: if (req) begin
                    state  <= WRITE;
                    pal_we <= (wr_req.target == WR_PALETTE);
                    fb_we  <= (wr_req.target == WR_FB);
                end
                WRITE:    state <= ACK_HIGH;
                ACK_HIGH: state <= req ? WAIT_LOW : IDLE;
                WAIT_LOW: if (!req) state <= IDLE;  // ack falls next cycle
                default:  state <= IDLE;
            endcase
        end
    end

    // request captured once, on the first req cycle
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && req) begin
            waddr <= wr_req.addr;
            wdata <= wr_req.data;
        end
    end

    assign ack = (state == ACK_HIGH) || (state == WAIT_LOW);

endmodule

// ==== verilog/line_fetch.sv ====
/* line fetch sequencer
   reads one framebuffer row per scaled line, maps it through the palette
   and fills the line buffer bank chosen by row parity */
`timescale 1ns/10ps

module line_fetch
    import video_pkg::*, pixel_pkg::*;
#(
    parameter int  V_ACTIVE  = V_ACTIVE_DEF,
    parameter int  V_TOTAL   = V_TOTAL_DEF,
    parameter int  SCALE     = SCALE_DEF,
    parameter int  FB_W      = H_ACTIVE_DEF / SCALE_DEF,
    parameter int  FB_ADDR_W = 17,
    localparam int LB_ADDR_W = $clog2(FB_W)
) (
    input  logic                 clk_pix,
    input  logic                 reset,
    input  timing_t              timing,
    output logic [FB_ADDR_W-1:0] fb_raddr,
    input  colour_idx_t          fb_rdata,
    output colour_idx_t          pal_raddr,
    input  rgb_t                 pal_rdata,
    output logic                 lb_we,
    output logic [LB_ADDR_W-1:0] lb_waddr,
    output rgb_t                 lb_wdata,
    output logic                 lb_bank
);

    localparam int SUB_W = $clog2(SCALE + 1);

    cord_t                next_y;      // line after the current one
    logic [SUB_W-1:0]     nsub_q;      // scale phase of next_y, from last line start
    logic [SUB_W-1:0]     nsub;
    logic                 fetch_start;
    logic [FB_ADDR_W-1:0] row_base_q;  // base of the last fetched row
    logic [FB_ADDR_W-1:0] new_base;
    logic                 bank_q;
    logic                 new_bank;
    logic                 busy;        // issuing fb reads
    logic [LB_ADDR_W-1:0] pix_cnt;
    logic [FB_ADDR_W-1:0] rd_addr_q;
    logic                 v1;          // fb data valid
    logic                 v2;          // palette data valid
    logic [LB_ADDR_W-1:0] wa1;
    logic [LB_ADDR_W-1:0] wa2;

    always_comb begin
        next_y = (timing.sy == cord_t'(V_TOTAL - 1)) ? '0 : timing.sy + 1'b1;
        if (next_y == '0) begin
            nsub = '0;  // frame restart
        end else if (nsub_q == SUB_W'(SCALE - 1)) begin
            nsub = '0;
        end else begin
            nsub = nsub_q + 1'b1;
        end
        // only the first line of each scaled row needs a fetch
        fetch_start = (timing.sx == '0) && (next_y < cord_t'(V_ACTIVE)) && (nsub == '0);
        new_base    = (next_y == '0) ? '0 : row_base_q + FB_ADDR_W'(FB_W);
        new_bank    = (next_y == '0) ? 1'b0 : ~bank_q;  // row parity
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            nsub_q     <= '0;  // line 0 phase
            row_base_q <= '0;
            bank_q     <= 1'b0;
            busy       <= 1'b0;
            pix_cnt    <= '0;
            rd_addr_q  <= '0;
            v1         <= 1'b0;
            v2         <= 1'b0;
        end else begin
            if (timing.sx == '0) nsub_q <= nsub;
            if (fetch_start) begin
                busy       <= 1'b1;
                pix_cnt    <= '0;
                rd_addr_q  <= new_base;
                row_base_q <= new_base;
                bank_q     <= new_bank;
            end else if (busy) begin
                pix_cnt   <= pix_cnt + 1'b1;
                rd_addr_q <= rd_addr_q + 1'b1;
                if (pix_cnt == LB_ADDR_W'(FB_W - 1)) busy <= 1'b0;  // last pixel issued
            end
            v1 <= busy;  // fb read latency
            v2 <= v1;    // palette read latency
        end
    end

    // buffer address follows the data through both RAM reads
    always_ff @(posedge clk_pix) begin
        wa1 <= pix_cnt;
        wa2 <= wa1;
    end

    assign fb_raddr  = rd_addr_q;
    assign pal_raddr = fb_rdata;  // index straight into the palette
    assign lb_we     = v2;
    assign lb_waddr  = wa2;
    assign lb_wdata  = pal_rdata;
    assign lb_bank   = bank_q;    // fixed for the whole fetch

endmodule

// ==== verilog/line_scaler.sv ====
/* line scaler
   ping-pong line buffer, replays the current row with each pixel repeated SCALE times */
`timescale 1ns/10ps

module line_scaler
    import video_pkg::*, pixel_pkg::*;
#(
    parameter int  SCALE     = SCALE_DEF,
    parameter int  FB_W      = H_ACTIVE_DEF / SCALE_DEF,
    localparam int LB_ADDR_W = $clog2(FB_W)
) (
    input  logic                 clk_pix,
    input  logic                 lb_we,
    input  logic [LB_ADDR_W-1:0] lb_waddr,
    input  rgb_t                 lb_wdata,
    input  logic                 lb_bank,
    input  timing_t              timing,
    output rgb_t                 pixel_rgb
);

    localparam int SUB_W = $clog2(SCALE + 1);

    logic                 line_start;
    logic [SUB_W-1:0]     h_sub_q;    // pixel repeat phase
    logic [SUB_W-1:0]     h_sub;
    logic [LB_ADDR_W-1:0] rd_addr_q;
    logic [LB_ADDR_W-1:0] rd_addr;    // sx / SCALE
    logic [SUB_W-1:0]     v_sub_q;    // line repeat phase
    logic [SUB_W-1:0]     v_sub;
    logic                 row_par_q;
    logic                 row_par;    // parity of sy / SCALE
    rgb_t                 bank0_rdata;
    rgb_t                 bank1_rdata;

    // counters restart combinationally at sx==0 so the first pixel is right
    always_comb begin
        line_start = (timing.sx == '0);
        h_sub      = line_start ? '0 : h_sub_q;
        rd_addr    = line_start ? '0 : rd_addr_q;
        if (!line_start) begin
            v_sub   = v_sub_q;
            row_par = row_par_q;
        end else if (timing.sy == '0) begin
            v_sub   = '0;    // top of frame, row 0
            row_par = 1'b0;
        end else if (v_sub_q == SUB_W'(SCALE - 1)) begin
            v_sub   = '0;    // next framebuffer row
            row_par = ~row_par_q;
        end else begin
            v_sub   = v_sub_q + 1'b1;
            row_par = row_par_q;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (h_sub == SUB_W'(SCALE - 1)) begin
            h_sub_q   <= '0;
            rd_addr_q <= rd_addr + 1'b1;  // step every SCALE pixels
        end else begin
            h_sub_q   <= h_sub + 1'b1;
            rd_addr_q <= rd_addr;
        end
        v_sub_q   <= v_sub;
        row_par_q <= row_par;  // also lines up with the RAM read latency
    end

    dual_port_ram #(
        .payload_t (rgb_t),
        .DEPTH     (FB_W)
    ) bank0 (
        .clk_pix,
        .we    (lb_we && !lb_bank),
        .waddr (lb_waddr),
        .wdata (lb_wdata),
        .raddr (rd_addr),
        .rdata (bank0_rdata)
    );

    dual_port_ram #(
        .payload_t (rgb_t),
        .DEPTH     (FB_W)
    ) bank1 (
        .clk_pix,
        .we    (lb_we && lb_bank),
        .waddr (lb_waddr),
        .wdata (lb_wdata),
        .raddr (rd_addr),
        .rdata (bank1_rdata)
    );

    assign pixel_rgb = row_par_q ? bank1_rdata : bank0_rdata;  // bank of the row on screen

endmodule

// ==== verilog/video_out.sv ====
/* video output stage
   delays sync and de two cycles to match the pixel path, blanks and registers colour */
`timescale 1ns/10ps

module video_out
    import video_pkg::*, pixel_pkg::*;
(
    input  logic    clk_pix,
    input  logic    reset,
    input  timing_t timing,
    input  rgb_t    pixel_rgb,  // one cycle behind timing
    output logic    hsync,
    output logic    vsync,
    output logic    de,
    output rgb_t    rgb
);

    logic hsync_d;  // first delay stage
    logic vsync_d;
    logic de_d;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            de_d    <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            de      <= 1'b0;
            rgb     <= '0;
        end else begin
            hsync_d <= timing.hsync;
            vsync_d <= timing.vsync;
            de_d    <= timing.de;
            hsync   <= hsync_d;
            vsync   <= vsync_d;
            de      <= de_d;
            rgb     <= de_d ? pixel_rgb : '0;  // black in blanking
        end
    end

endmodule

// ==== verilog/fb_display_top.sv ====
/* framebuffer display top level
   host write port, palette, framebuffer, line fetch, line scaler and video output */
`timescale 1ns/10ps

module fb_display_top
    import video_pkg::*, pixel_pkg::*;
#(
    parameter int H_ACTIVE     = H_ACTIVE_DEF,
    parameter int H_TOTAL      = H_TOTAL_DEF,
    parameter int H_SYNC_START = H_SYNC_START_DEF,
    parameter int H_SYNC_END   = H_SYNC_END_DEF,
    parameter int V_ACTIVE     = V_ACTIVE_DEF,
    parameter int V_TOTAL      = V_TOTAL_DEF,
    parameter int V_SYNC_START = V_SYNC_START_DEF,
    parameter int V_SYNC_END   = V_SYNC_END_DEF,
    parameter int SCALE        = SCALE_DEF
) (
    input  logic    clk_pix,
    input  logic    reset,
    input  logic    req,
    input  wr_req_t wr_req,
    output logic    ack,
    output logic    hsync,
    output logic    vsync,
    output logic    de,
    output rgb_t    rgb
);

    localparam int FB_W      = H_ACTIVE / SCALE;
    localparam int FB_H      = V_ACTIVE / SCALE;
    localparam int FB_ADDR_W = $clog2(FB_W * FB_H);
    localparam int LB_ADDR_W = $clog2(FB_W);

    timing_t              timing;
    logic                 pal_we;
    logic                 fb_we;
    logic [16:0]          hw_waddr;  // host address, sliced per RAM
    logic [11:0]          hw_wdata;
    logic [FB_ADDR_W-1:0] fb_raddr;
    colour_idx_t          fb_rdata;
    colour_idx_t          pal_raddr;
    rgb_t                 pal_rdata;
    logic                 lb_we;
    logic [LB_ADDR_W-1:0] lb_waddr;
    rgb_t                 lb_wdata;
    logic                 lb_bank;
    rgb_t                 pixel_rgb;

    display_timing #(
        .H_ACTIVE (H_ACTIVE), .H_TOTAL (H_TOTAL),
        .H_SYNC_START (H_SYNC_START), .H_SYNC_END (H_SYNC_END),
        .V_ACTIVE (V_ACTIVE), .V_TOTAL (V_TOTAL),
        .V_SYNC_START (V_SYNC_START), .V_SYNC_END (V_SYNC_END)
    ) u_timing (.clk_pix, .reset, .timing);

    host_write_port u_host (
        .clk_pix, .reset, .req, .wr_req, .ack, .pal_we, .fb_we,
        .waddr (hw_waddr),
        .wdata (hw_wdata)
    );

    // colour lookup, 64 entries of rgb444
    dual_port_ram #(.payload_t (rgb_t), .DEPTH (64)) u_palette (
        .clk_pix, .we (pal_we),
        .waddr (hw_waddr[CIDX_W-1:0]), .wdata (rgb_t'(hw_wdata)),
        .raddr (pal_raddr), .rdata (pal_rdata)
    );

    // indexed framebuffer, row major
    dual_port_ram #(.payload_t (colour_idx_t), .DEPTH (FB_W * FB_H)) u_fb (
        .clk_pix, .we (fb_we),
        .waddr (hw_waddr[FB_ADDR_W-1:0]), .wdata (colour_idx_t'(hw_wdata[CIDX_W-1:0])),
        .raddr (fb_raddr), .rdata (fb_rdata)
    );

    line_fetch #(
        .V_ACTIVE (V_ACTIVE), .V_TOTAL (V_TOTAL), .SCALE (SCALE),
        .FB_W (FB_W), .FB_ADDR_W (FB_ADDR_W)
    ) u_fetch (
        .clk_pix, .reset, .timing, .fb_raddr, .fb_rdata, .pal_raddr, .pal_rdata,
        .lb_we, .lb_waddr, .lb_wdata, .lb_bank
    );

    line_scaler #(.SCALE (SCALE), .FB_W (FB_W)) u_scaler (
        .clk_pix, .lb_we, .lb_waddr, .lb_wdata, .lb_bank, .timing, .pixel_rgb
    );

    video_out u_out (
        .clk_pix, .reset, .timing, .pixel_rgb, .hsync, .vsync, .de, .rgb
    );

endmodule

// ==== testbench/tb_fb_display.sv ====
/* framebuffer display testbench
   loads palette and framebuffer from the stimulus file, then checks sync, blanking,
   the host handshake and every displayed pixel against a palette and framebuffer model */
`timescale 1ns/10ps

module tb_fb_display
    import pixel_pkg::*;
();

    // tiny screen, 8x4 framebuffer
    localparam int H_ACTIVE     = 16;
    localparam int H_TOTAL      = 28;
    localparam int H_SYNC_START = 20;
    localparam int H_SYNC_END   = 23;
    localparam int V_ACTIVE     = 8;
    localparam int V_TOTAL      = 12;
    localparam int V_SYNC_START = 9;
    localparam int V_SYNC_END   = 10;
    localparam int SCALE        = 2;
    localparam int FB_W         = H_ACTIVE / SCALE;
    localparam int FB_N         = FB_W * (V_ACTIVE / SCALE);
    localparam int FB_ADDR_W    = $clog2(FB_N);
    localparam int STIM_N       = 37;   // entries in the stimulus file
    localparam int CLK_PERIOD   = 40;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = (STIM_N * 8 + 5) * FRAME_CYCLES;

    logic    clk_pix = 1'b0;
    logic    reset;
    logic    req;
    wr_req_t wr_req;
    logic    ack;
    logic    hsync;
    logic    vsync;
    logic    de;
    rgb_t    rgb;

    logic [31:0] stim [STIM_N];   // {2'b0, target, addr, data}
    rgb_t        pal_model [64];  // mirrors of every host write
    colour_idx_t fb_model [FB_N];
    rgb_t        pal_shown [64];  // snapshot taken at frame start
    colour_idx_t fb_shown [FB_N];
    rgb_t        new_colour;      // value of the mid-run palette rewrite
    rgb_t        exp_rgb;

    integer seed = 32'h770;
    int     pix_errs = 0;
    int     sync_errs = 0;
    int     hs_errs = 0;
    int     req_rises = 0;
    int     ack_rises = 0;
    int     frame_count = 0;      // vsync rises seen
    int     checked_frames = 0;   // complete frames compared pixel by pixel
    int     new_hits = 0;
    int     last_frame;
    logic   check_on = 1'b0;      // main asks for pixel checks from next frame
    logic   check_frame = 1'b0;   // current frame is being compared

    // output monitor state
    logic hsync_q = 1'b0;
    logic vsync_q = 1'b0;
    logic de_q = 1'b0;
    logic ack_q = 1'b0;
    int   hs_cnt = 0;
    int   line_cnt = 0;
    int   de_run = 0;
    int   pix_idx = 0;
    int   vs_len = 0;

    fb_display_top #(
        .H_ACTIVE (H_ACTIVE), .H_TOTAL (H_TOTAL),
        .H_SYNC_START (H_SYNC_START), .H_SYNC_END (H_SYNC_END),
        .V_ACTIVE (V_ACTIVE), .V_TOTAL (V_TOTAL),
        .V_SYNC_START (V_SYNC_START), .V_SYNC_END (V_SYNC_END),
        .SCALE (SCALE)
    ) uut (
        .clk_pix, .reset, .req, .wr_req, .ack, .hsync, .vsync, .de, .rgb
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    // palette entry of the framebuffer pixel under screen pixel idx
    function automatic rgb_t expected_pixel(input int idx);
        int x;
        int y;
        x = idx % H_ACTIVE;
        y = idx / H_ACTIVE;
        return pal_shown[fb_shown[FB_ADDR_W'((y / SCALE) * FB_W + x / SCALE)]];
    endfunction

    task automatic check_zero(input string name, input logic [11:0] value);
        if (value !== 12'h000) begin
            $display("Error: %s is %h in reset, expected %h", name, value, 12'h000);
            sync_errs++;
        end
    endtask

    // one four-phase write, model updated once ack is gone
    task automatic host_write(input wr_req_t w);
        int gap;
        gap = $random(seed) & 3;  // idle cycles before the request
        repeat (gap) @(posedge clk_pix);
        @(posedge clk_pix);
        wr_req <= w;              // data settles a cycle before req
        @(posedge clk_pix);
        req <= 1'b1;
        req_rises++;
        do @(negedge clk_pix); while (!ack);
        @(posedge clk_pix);
        req <= 1'b0;
        do @(negedge clk_pix); while (ack);
        if (w.target == WR_PALETTE) begin
            pal_model[w.addr[CIDX_W-1:0]] = rgb_t'(w.data);
        end else begin
            fb_model[w.addr[FB_ADDR_W-1:0]] = w.data[CIDX_W-1:0];  // low 6 bits only
        end
    endtask

    task automatic set_checking(input logic on);
        @(posedge clk_pix);
        check_on <= on;
    endtask

    // sync, blanking and pixel checks, sampled mid cycle
    always @(negedge clk_pix) begin
        if (!reset) begin
            if (!de && rgb != 12'h000) begin
                $display("Error: rgb is %h with de low, expected %h", rgb, 12'h000);
                pix_errs++;
            end
            if (vsync && !vsync_q) begin  // frame boundary
                if (frame_count > 0 && hs_cnt != V_TOTAL) begin
                    $display("Error: hsync pulses per frame %h, expected %h", hs_cnt, V_TOTAL);
                    sync_errs++;
                end
                if (frame_count > 0 && line_cnt != V_ACTIVE) begin
                    $display("Error: de lines per frame %h, expected %h", line_cnt, V_ACTIVE);
                    sync_errs++;
                end
                if (check_frame) checked_frames++;
                check_frame = check_on;
                if (check_on) begin
                    pal_shown = pal_model;
                    fb_shown  = fb_model;
                end
                hs_cnt   = 0;
                line_cnt = 0;
                pix_idx  = 0;
                vs_len   = 0;
                frame_count++;
            end
            if (vsync) vs_len++;
            if (!vsync && vsync_q && vs_len != (V_SYNC_END - V_SYNC_START) * H_TOTAL) begin
                $display("Error: vsync length %h, expected %h", vs_len,
                         (V_SYNC_END - V_SYNC_START) * H_TOTAL);
                sync_errs++;
            end
            if (hsync && !hsync_q) hs_cnt++;
            if (de) begin
                if (check_frame) begin
                    exp_rgb = expected_pixel(pix_idx);
                    if (rgb !== exp_rgb) begin
                        $display("Error: rgb at pixel %0d is %h, expected %h",
                                 pix_idx, rgb, exp_rgb);
                        pix_errs++;
                    end else if (exp_rgb == new_colour) begin
                        new_hits++;
                    end
                end
                pix_idx++;
                de_run++;
            end else if (de_q) begin  // end of an active line
                if (de_run != H_ACTIVE) begin
                    $display("Error: de line length %h, expected %h", de_run, H_ACTIVE);
                    sync_errs++;
                end
                line_cnt++;
                de_run = 0;
            end
        end
        hsync_q = hsync;
        vsync_q = vsync;
        de_q    = de;
    end

    // four-phase rules seen from the host side
    always @(negedge clk_pix) begin
        if (!reset) begin
            if (ack && !ack_q) begin
                ack_rises++;
                if (!req) begin
                    $display("handshake: ack rose while req was low");
                    hs_errs++;
                end
            end
            if (!ack && ack_q && req) begin
                $display("handshake: ack dropped while req was still high");
                hs_errs++;
            end
        end
        ack_q = ack;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, errors %0d pixel %0d sync %0d handshake",
                 WATCHDOG_CYCLES, pix_errs, sync_errs, hs_errs);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset  = 1'b1;
        req    = 1'b0;
        wr_req = '0;
        $readmemh("testbench/fb_stimulus.mem", stim);
        new_colour = rgb_t'(stim[STIM_N-1][11:0]);  // last entry is the rewrite
        repeat (15) @(posedge clk_pix);
        @(negedge clk_pix);
        check_zero("ack", 12'(ack));
        check_zero("hsync", 12'(hsync));
        check_zero("vsync", 12'(vsync));
        check_zero("de", 12'(de));
        check_zero("rgb", rgb);
        @(posedge clk_pix);
        reset <= 1'b0;  // 16 cycles in reset
        for (int i = 0; i < STIM_N - 1; i++) begin
            host_write(wr_req_t'(stim[i][29:0]));
        end
        set_checking(1'b1);
        wait (checked_frames >= 2);
        set_checking(1'b0);
        last_frame = frame_count;
        wait (frame_count > last_frame);  // frame in flight still checked
        host_write(wr_req_t'(stim[STIM_N-1][29:0]));
        set_checking(1'b1);
        wait (checked_frames >= 5);       // first frame after the rewrite plus one
        if (ack_rises != req_rises) begin
            $display("handshake: %0d requests got %0d acks", req_rises, ack_rises);
            hs_errs++;
        end
        if (new_hits == 0) begin
            $display("the rewritten palette colour never reached the screen");
            pix_errs++;
        end
        $display("errors: %0d pixel, %0d sync, %0d handshake", pix_errs, sync_errs, hs_errs);
        if (pix_errs + sync_errs + hs_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/fb_stimulus.mem ====
// one host write per line: {2'b00, target, addr[16:0], data[11:0]}
// target 0 is palette (data rgb444), 1 is framebuffer (data colour index); last line rewrites
00000123
00001F00
000020F0
0000300F
20000000
20001001
20002002
20003003
20004001
20005002
20006003
20007000
20008002
20009003
2000A000
2000B001
2000C003
2000D000
2000E001
2000F002
20010001
20011002
20012003
20013000
20014002
20015003
20016000
20017001
20018003
20019000
2001A001
2001B002
2001C000
2001D001
2001E002
2001F003
00002ABC

// ==== sim.f ====
verilog/video_pkg.sv
verilog/pixel_pkg.sv
verilog/dual_port_ram.sv
verilog/display_timing.sv
verilog/host_write_port.sv
verilog/line_fetch.sv
verilog/line_scaler.sv
verilog/video_out.sv
verilog/fb_display_top.sv
testbench/tb_fb_display.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_fb_display
FILELIST  = sim.f

.PHONY: run clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
